//--- common/sram_settings.svh
// Width and depth macros for the SRAM subsystem that every file sizing a bus or array includes
`ifndef SRAM_SETTINGS_SVH
`define SRAM_SETTINGS_SVH

// Width of one RAM word in bits
`define SRAM_DATA_W 32

// Number of byte lanes in a word, one mask bit per lane
`define SRAM_BYTES (`SRAM_DATA_W / 8)

// Number of words held by the RAM
`define SRAM_DEPTH 64

// Word address width derived from the depth
`define SRAM_ADDR_W $clog2(`SRAM_DEPTH)

`endif

//--- common/sram_pkg.sv
// Shared types for the SRAM subsystem that every RTL module references by scoped name
`include "sram_settings.svh"

package sram_pkg;

  // Word address into the RAM array
  typedef logic [`SRAM_ADDR_W-1:0] addr_t;

  // One full data word
  typedef logic [`SRAM_DATA_W-1:0] data_t;

  // Byte mask with bit i covering byte lane i
  typedef logic [`SRAM_BYTES-1:0] bmask_t;

  // Controller states
  // CLEAR walks every word and writes zero, SERVE hands the port to the user
  typedef enum logic {
    CLEAR,
    SERVE
  } ctrl_state_e;

  // User request as it arrives at the top level
  // A request with we low is a read and wdata and bmask are then ignored
  typedef struct packed {
    logic   we;
    addr_t  addr;
    data_t  wdata;
    bmask_t bmask;
  } mem_req_t;

  // Control bundle seen by the RAM macro
  // Both strobes are active low as on a typical compiled memory
  typedef struct packed {
    logic   en_n;
    logic   wen_n;
    addr_t  addr;
    data_t  wdata;
    bmask_t bmask;
  } ram_ctrl_t;

endpackage

//--- design/sram_fsm.sv
// Controller FSM that runs the power-up clear of the RAM and then hands the port to user requests
`timescale 1ns/1ns

module sram_fsm (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic last_i,
  output logic clear_en_o,
  output logic busy_o
);

  // Current and next state of the controller
  sram_pkg::ctrl_state_e state_q;
  sram_pkg::ctrl_state_e state_d;

  // Next-state logic
  always_comb begin
    state_d = state_q;
    case (state_q)
      sram_pkg::CLEAR: begin
        // The counter sits on the final word this cycle so clearing ends at this edge
        if (last_i) begin
          state_d = sram_pkg::SERVE;
        end
      end
      sram_pkg::SERVE: begin
        // Normal service lasts until the next reset
        state_d = sram_pkg::SERVE;
      end
      default: begin
        state_d = sram_pkg::CLEAR;
      end
    endcase
  end

  // State register
  // Reset drops the controller back into clearing so the RAM is wiped again
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= sram_pkg::CLEAR;
    end else begin
      state_q <= state_d;
    end
  end

  // The clearing path and the counter are enabled for the whole CLEAR state
  assign clear_en_o = (state_q == sram_pkg::CLEAR);

  // Busy mirrors the clearing state
  // It is high through reset and falls at the edge that performs the last clearing write
  assign busy_o = (state_q == sram_pkg::CLEAR);

endmodule

//--- design/init_counter.sv
// Word-address counter that steps through the whole RAM once during the power-up clear
`timescale 1ns/1ns

`include "sram_settings.svh"

module init_counter (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            en_i,
  output sram_pkg::addr_t addr_o,
  output logic            last_o
);

  // Address of the word being cleared in this cycle
  sram_pkg::addr_t count_q;

  // Count register
  // It starts at word zero and moves on by one word per enabled cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (en_i) begin
      // After the final word the count wraps to zero as the enable drops
      count_q <= count_q + 1'b1;
    end
  end

  // The clearing write uses the current count directly
  assign addr_o = count_q;

  // Final word flag for the FSM
  // Kept combinational so the FSM leaves CLEAR at the same edge as the last write
  assign last_o = (count_q == sram_pkg::addr_t'(`SRAM_DEPTH - 1));

endmodule

//--- design/mem_port_mux.sv
// Port mux that puts either clearing writes or user requests on the single RAM port
`timescale 1ns/1ns

module mem_port_mux (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                clear_en_i,
  input  sram_pkg::addr_t     clear_addr_i,
  input  logic                req_i,
  input  sram_pkg::mem_req_t  req_i_data,
  output sram_pkg::ram_ctrl_t ram_o,
  output logic                rvalid_o
);

  // High when a user read is handed to the RAM this cycle
  logic rd_accept;

  // High when a user request of either kind reaches the RAM this cycle
  logic req_accept;

  // User strobes only count once clearing is over
  // A strobe during clearing is simply dropped
  assign req_accept = req_i && !clear_en_i;
  assign rd_accept  = req_accept && !req_i_data.we;

  // RAM control selection
  always_comb begin
    // Idle port keeps both strobes high and passes the user fields through
    ram_o.en_n  = 1'b1;
    ram_o.wen_n = 1'b1;
    ram_o.addr  = req_i_data.addr;
    ram_o.wdata = req_i_data.wdata;
    ram_o.bmask = req_i_data.bmask;

    if (clear_en_i) begin
      // Clearing writes zero to the counter address
      // The full mask makes the whole word take the zero value
      ram_o.en_n  = 1'b0;
      ram_o.wen_n = 1'b0;
      ram_o.addr  = clear_addr_i;
      ram_o.wdata = '0;
      ram_o.bmask = '1;
    end else if (req_accept) begin
      // A write request drives both strobes low
      // A read keeps write-enable high so the RAM returns the word
      ram_o.en_n  = 1'b0;
      ram_o.wen_n = !req_i_data.we;
    end
  end

  // Read-valid register
  // The RAM registers its output at the same edge, so the pulse and the data line up
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= rd_accept;
    end
  end

endmodule

//--- ram/tech_ram_bm.sv
// Behavioral single-port RAM with active-low strobes, byte mask and a registered read port
`timescale 1ns/1ns

`include "sram_settings.svh"

module tech_ram_bm (
  input  logic                clk_i,
  input  sram_pkg::ram_ctrl_t ram_i,
  output sram_pkg::data_t     dat_o
);

  // Storage array with one entry per word
  sram_pkg::data_t mem_q [`SRAM_DEPTH];

  // Write data after the byte mask has been applied
  sram_pkg::data_t wdata_masked;

  // Mask bit i gates byte lane i
  // A lane whose mask bit is 0 is stored as zero and its old contents are lost
  always_comb begin
    for (int i = 0; i < `SRAM_BYTES; i++) begin
      wdata_masked[i*8+:8] = ram_i.wdata[i*8+:8] & {8{ram_i.bmask[i]}};
    end
  end

  // Array access
  always_ff @(posedge clk_i) begin
    if (!ram_i.en_n && !ram_i.wen_n) begin
      // Write cycle leaves the read register untouched
      mem_q[ram_i.addr] <= wdata_masked;
    end else if (!ram_i.en_n) begin
      // Read cycle registers the addressed word
      dat_o <= mem_q[ram_i.addr];
    end else begin
      // Idle cycle fills the output with noise, as an unselected macro would
      dat_o <= {(`SRAM_DATA_W / 32){$urandom}};
    end
  end

endmodule

//--- design/sram_subsys_top.sv
// Top level of the SRAM subsystem that wires the controller, clear counter, port mux and RAM
`timescale 1ns/1ns

module sram_subsys_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               req_i,
  input  sram_pkg::mem_req_t req_i_data,
  output logic               busy_o,
  output sram_pkg::data_t    rdata_o,
  output logic               rvalid_o
);

  // Final-word flag from the counter to the FSM
  logic last;

  // Clearing enable from the FSM to the counter and the mux
  logic clear_en;

  // Word address being cleared
  sram_pkg::addr_t clear_addr;

  // Control bundle from the mux to the RAM
  sram_pkg::ram_ctrl_t ram_ctrl;

  // Controller FSM
  sram_fsm i_sram_fsm (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .last_i     (last),
    .clear_en_o (clear_en),
    .busy_o     (busy_o)
  );

  // Address counter for the power-up clear
  init_counter i_init_counter (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .en_i    (clear_en),
    .addr_o  (clear_addr),
    .last_o  (last)
  );

  // Port mux between clearing and user traffic
  mem_port_mux i_mem_port_mux (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .clear_en_i   (clear_en),
    .clear_addr_i (clear_addr),
    .req_i        (req_i),
    .req_i_data   (req_i_data),
    .ram_o        (ram_ctrl),
    .rvalid_o     (rvalid_o)
  );

  // RAM macro with its read register driving the output directly
  tech_ram_bm i_tech_ram_bm (
    .clk_i (clk_i),
    .ram_i (ram_ctrl),
    .dat_o (rdata_o)
  );

endmodule

//--- verif/tb_clkgen.sv
// Testbench clock and reset source that the top-level testbench instantiates once
`timescale 1ns/1ns

module tb_clkgen #(
  parameter int PERIOD = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  // Free-running clock that starts low
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD / 2) clk_o = ~clk_o;
    end
  end

  // Reset is held for two rising edges and released after the second one
  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

//--- verif/sram_tb.sv
// Table-driven testbench for the SRAM subsystem that compares every cycle with a reference memory
`timescale 1ns/1ns

`include "sram_settings.svh"

module sram_tb;

  localparam int PERIOD = 4;
  // Spare cycles for reset, pipeline drain and slack on top of clearing and the table
  localparam int MARGIN = 40;

  // One table row whose expected word the reference model fills in while the table is built
  typedef struct packed {
    int                 test;
    logic               req;
    sram_pkg::mem_req_t rq;
    sram_pkg::data_t    exp;
  } entry_t;

  logic               clk;
  logic               rst_n;
  logic               req;
  sram_pkg::mem_req_t req_data;
  logic               busy;
  sram_pkg::data_t    rdata;
  logic               rvalid;

  entry_t          table_q[$];
  sram_pkg::data_t ref_mem [`SRAM_DEPTH];
  logic [31:0]     lfsr_q = 32'hdc38;
  logic            table_ready = 1'b0;
  int              checks = 0;
  int              errors = 0;
  int              test_checks = 0;
  int              test_errors = 0;
  int              tests_passed = 0;
  int              tests_failed = 0;
  string           test_names [6] = '{"clear", "read after clear", "full mask write",
                                      "partial mask write", "back-to-back reads", "random mix"};

  tb_clkgen #(.PERIOD(PERIOD)) i_tb_clkgen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  sram_subsys_top i_sram_subsys_top (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .req_i      (req),
    .req_i_data (req_data),
    .busy_o     (busy),
    .rdata_o    (rdata),
    .rvalid_o   (rvalid)
  );

  // Fibonacci LFSR with taps 32, 22, 2 and 1 that shifts the feedback in at the bottom
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One LFSR step per bit handed out
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Bytes with a clear mask bit are stored as zero and never kept from the old word
  function automatic sram_pkg::data_t mask_bytes(input sram_pkg::data_t d,
                                                 input sram_pkg::bmask_t m);
    sram_pkg::data_t r;
    r = '0;
    for (int b = 0; b < `SRAM_BYTES; b++) begin
      if (m[b]) begin
        r[b*8+:8] = d[b*8+:8];
      end
    end
    return r;
  endfunction

  // Appends a row and runs it through the reference memory
  task automatic add_entry(input int test, input logic go, input logic we,
                           input sram_pkg::addr_t addr, input sram_pkg::data_t data,
                           input sram_pkg::bmask_t mask);
    entry_t e;
    e.test     = test;
    e.req      = go;
    e.rq.we    = we;
    e.rq.addr  = addr;
    e.rq.wdata = data;
    e.rq.bmask = mask;
    e.exp      = '0;
    if (go && we) begin
      ref_mem[addr] = mask_bytes(data, mask);
    end else if (go) begin
      e.exp = ref_mem[addr];
    end
    table_q.push_back(e);
  endtask

  task automatic build_table();
    logic             go;
    logic             we;
    sram_pkg::addr_t  addr;
    sram_pkg::data_t  data;
    sram_pkg::bmask_t mask;
    // The clear leaves every word at zero and the strobes given while busy change nothing
    foreach (ref_mem[a]) begin
      ref_mem[a] = '0;
    end
    for (int a = 0; a <= 8; a++) begin
      add_entry(1, 1'b1, 1'b0, sram_pkg::addr_t'(a), '0, '0);
    end
    add_entry(1, 1'b1, 1'b0, sram_pkg::addr_t'(`SRAM_DEPTH - 1), '0, '0);
    add_entry(2, 1'b1, 1'b1, 6'd5, 32'h1234_5678, 4'hf);
    add_entry(2, 1'b1, 1'b0, 6'd5, '0, '0);
    add_entry(2, 1'b1, 1'b1, 6'd20, 32'ha5c3_0f96, 4'hf);
    add_entry(2, 1'b0, 1'b0, 6'd0, '0, '0);
    add_entry(2, 1'b1, 1'b0, 6'd20, '0, '0);
    // Mask bit i covers byte i, so the second write also wipes the bytes kept by the first
    add_entry(3, 1'b1, 1'b1, 6'd9, 32'hcafe_f00d, 4'b0101);
    add_entry(3, 1'b1, 1'b0, 6'd9, '0, '0);
    add_entry(3, 1'b1, 1'b1, 6'd9, 32'h7e57_1d2b, 4'b1000);
    add_entry(3, 1'b1, 1'b0, 6'd9, '0, '0);
    for (int a = 30; a < 33; a++) begin
      add_entry(4, 1'b1, 1'b1, sram_pkg::addr_t'(a), 32'h0101_0101 * a, 4'hf);
    end
    for (int a = 30; a < 33; a++) begin
      add_entry(4, 1'b1, 1'b0, sram_pkg::addr_t'(a), '0, '0);
    end
    // Random traffic stays in an eight-word window so that reads often hit written words
    for (int i = 0; i < 40; i++) begin
      go   = (random_bits(2) != 0);
      we   = (random_bits(1) != 0);
      addr = sram_pkg::addr_t'(40 + random_bits(3));
      data = random_bits(32);
      mask = sram_pkg::bmask_t'(random_bits(`SRAM_BYTES));
      add_entry(5, go, we, addr, data, mask);
    end
  endtask

  task automatic tally_check(input logic ok);
    checks++;
    test_checks++;
    if (!ok) begin
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h at %0t ns", name, got, exp, $time);
    end
    tally_check(got === exp);
  endtask

  task automatic check_data(input string name, input sram_pkg::data_t got,
                            input sram_pkg::data_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h at %0t ns", name, got, exp, $time);
    end
    tally_check(got === exp);
  endtask

  task automatic report_test(input int t);
    $display("test %0d (%s) done with %0d checks and %0d errors", t, test_names[t],
             test_checks, test_errors);
    if (test_errors == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
    test_checks = 0;
    test_errors = 0;
  endtask

  initial begin
    int busy_cycles;
    int j;
    logic rd;
    req         = 1'b0;
    req_data    = '0;
    busy_cycles = 0;
    build_table();
    table_ready = 1'b1;
    wait (rst_n === 1'b1);
    // The clearing phase is sampled at the falling edge while a few strobes must be dropped
    @(negedge clk);
    while (busy === 1'b1) begin
      busy_cycles++;
      check_bit("rvalid_o", rvalid, 1'b0);
      @(posedge clk);
      if (busy_cycles <= 8) begin
        req      <= 1'b1;
        req_data <= '{we: busy_cycles[0], addr: sram_pkg::addr_t'(busy_cycles),
                      wdata: '1, bmask: '1};
      end else begin
        req <= 1'b0;
      end
      @(negedge clk);
    end
    tally_check(busy_cycles == `SRAM_DEPTH);
    if (busy_cycles != `SRAM_DEPTH) begin
      $display("busy_o stayed high for %0d cycles after reset instead of %0d", busy_cycles,
               `SRAM_DEPTH);
    end
    report_test(0);
    // Each iteration drives row k and checks the response to row k-1
    for (int k = 0; k <= table_q.size(); k++) begin
      @(posedge clk);
      if (k < table_q.size()) begin
        req      <= table_q[k].req;
        req_data <= table_q[k].rq;
      end else begin
        req <= 1'b0;
      end
      @(negedge clk);
      if (k > 0) begin
        j  = k - 1;
        rd = table_q[j].req && !table_q[j].rq.we;
        check_bit("busy_o", busy, 1'b0);
        check_bit("rvalid_o", rvalid, rd);
        if (rd) begin
          check_data("rdata_o", rdata, table_q[j].exp);
        end
        if (k == table_q.size() || table_q[k].test != table_q[j].test) begin
          report_test(table_q[j].test);
        end
      end
    end
    $display("Summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
             tests_passed, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog sized from the clearing length and the table length
  initial begin
    wait (table_ready);
    #((table_q.size() + `SRAM_DEPTH + MARGIN) * PERIOD);
    $display("Watchdog expired before the tests completed");
    $display("Result: FAILED");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+common
common/sram_pkg.sv
design/sram_fsm.sv
design/init_counter.sv
design/mem_port_mux.sv
ram/tech_ram_bm.sv
design/sram_subsys_top.sv
verif/tb_clkgen.sv
verif/sram_tb.sv

//--- run.sh
#!/bin/sh
# Builds the SRAM subsystem testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f vlog.f --top-module sram_tb -o sram_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sram_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^Result: PASSED$"; then
  exit 0
fi
exit 1
